/* Bender.yml */
package:
  name: fetch_predict

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/bp_pkg.sv
      - hw/pc_gen.sv
      - hw/two_bit_btb.sv
      - hw/fetch_queue.sv
      - hw/branch_resolve.sv
      - hw/fetch_predict_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/fetch_predict_properties.sv
      - verification/tb_fetch_predict.sv

/* compile.f */
+incdir+include
hw/bp_pkg.sv
hw/pc_gen.sv
hw/two_bit_btb.sv
hw/fetch_queue.sv
hw/branch_resolve.sv
hw/fetch_predict_top.sv
verification/fetch_predict_properties.sv
verification/tb_fetch_predict.sv

/* hw/bp_pkg.sv */
// instruction union with B and J format views, opcodes
// and the saturating counter type of the target buffer
package bp_pkg;

    // conditional branch and jal opcodes
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;

    // B format, immediate scattered over both ends of the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // J format used by jal
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, read both ways by the resolve stage
    // opcode sits in bits 6:0 of either view
    typedef union packed {
        b_fmt_t b;
        j_fmt_t j;
    } rv_instr_u;

    // 2-bit counter, 11 and 10 predict taken
    // 00 <-> 01 <-> 10 <-> 11
    typedef logic [1:0] ctr_t;

    // value written when an entry is allocated
    localparam ctr_t CTR_INIT = 2'b00;

endpackage

/* hw/branch_resolve.sv */
// resolve stage, pairs queue head with its instruction word
// decodes branch and jal, trains the buffer, raises redirects
`timescale 1ns/100ps

module branch_resolve (
    input  logic              clk,
    input  logic              rst,
    input  logic              head_valid,
    input  logic [31:0]       head_pc,
    input  logic [31:0]       head_pred,
    input  logic              instr_valid,
    input  bp_pkg::rv_instr_u instr,
    input  logic              cond_taken,
    output logic              head_ready,
    output logic              upd_valid,
    output logic [31:0]       upd_pc,
    output logic              upd_is_br,
    output logic              upd_taken,
    output logic [31:0]       upd_target,
    output logic              redirect_valid,
    output logic [31:0]       redirect_pc,
    output logic              retire_valid
);

    logic        pop;
    logic        is_branch;
    logic        is_jal;
    logic        is_br;
    logic        taken;
    logic [31:0] b_imm;
    logic [31:0] j_imm;
    logic [31:0] target;
    logic [31:0] actual_pc;
    logic        mispredict;

    // memory answers for the head entry
    assign head_ready = instr_valid;

    // head during our own redirect is being flushed, not resolved
    assign pop = head_valid && instr_valid && !redirect_valid;

    // opcode is at the same bits in both views
    assign is_branch = (instr.b.opcode == bp_pkg::OPC_BRANCH);
    assign is_jal    = (instr.j.opcode == bp_pkg::OPC_JAL);
    assign is_br     = is_branch || is_jal;

    // sign-extended immediates, bit 0 always zero
    assign b_imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign j_imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    assign target = head_pc + (is_jal ? j_imm : b_imm);

    // jal always taken, branch condition comes from outside
    assign taken = is_jal || (is_branch && cond_taken);

    // true successor
    assign actual_pc = taken ? target : head_pc + 32'd4;

    assign mispredict = (actual_pc != head_pred);

    always_ff @(posedge clk) begin
        if (rst) begin
            upd_valid      <= 1'b0;
            redirect_valid <= 1'b0;
            retire_valid   <= 1'b0;
        end else begin
            upd_valid      <= pop;
            retire_valid   <= pop;
            // single-cycle pulse, pop is blocked while it is high
            redirect_valid <= pop && mispredict;
        end
    end

    // training record and redirect address
    always_ff @(posedge clk) begin
        upd_pc      <= head_pc;
        upd_is_br   <= is_br;
        upd_taken   <= taken;
        upd_target  <= target;
        redirect_pc <= actual_pc;
    end

endmodule

/* hw/fetch_predict_top.sv */
// fetch predictor top
// pc generator, target buffer, fetch queue and resolve stage
`timescale 1ns/100ps

module fetch_predict_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  bp_pkg::rv_instr_u instr,
    input  logic              cond_taken,
    output logic [31:0]       fetch_pc,
    output logic              fetch_valid,
    output logic              redirect_valid,
    output logic [31:0]       redirect_pc,
    output logic              retire_valid
);

    // generator side
    logic [31:0] lookup_pc;
    logic [31:0] pred_pc;
    logic        push_valid;
    logic        push_ready;
    logic [31:0] push_pc;
    logic [31:0] push_pred;

    // queue head
    logic        head_valid;
    logic        head_ready;
    logic [31:0] head_pc;
    logic [31:0] head_pred;

    // buffer training
    logic        upd_valid;
    logic [31:0] upd_pc;
    logic        upd_is_br;
    logic        upd_taken;
    logic [31:0] upd_target;

    pc_gen u_pc_gen (
        .clk            (clk),
        .rst            (rst),
        .pred_pc        (pred_pc),
        .push_ready     (push_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .lookup_pc      (lookup_pc),
        .push_valid     (push_valid),
        .push_pc        (push_pc),
        .push_pred      (push_pred)
    );

    two_bit_btb u_btb (
        .clk        (clk),
        .rst        (rst),
        .lookup_pc  (lookup_pc),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_is_br  (upd_is_br),
        .upd_taken  (upd_taken),
        .upd_target (upd_target),
        .pred_pc    (pred_pc)
    );

    // redirect flushes everything queued behind the mispredicted pc
    fetch_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .flush      (redirect_valid),
        .push_valid (push_valid),
        .push_pc    (push_pc),
        .push_pred  (push_pred),
        .head_ready (head_ready),
        .push_ready (push_ready),
        .head_valid (head_valid),
        .head_pc    (head_pc),
        .head_pred  (head_pred)
    );

    branch_resolve u_resolve (
        .clk            (clk),
        .rst            (rst),
        .head_valid     (head_valid),
        .head_pc        (head_pc),
        .head_pred      (head_pred),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .cond_taken     (cond_taken),
        .head_ready     (head_ready),
        .upd_valid      (upd_valid),
        .upd_pc         (upd_pc),
        .upd_is_br      (upd_is_br),
        .upd_taken      (upd_taken),
        .upd_target     (upd_target),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .retire_valid   (retire_valid)
    );

    // memory model reads the head address
    assign fetch_pc    = head_pc;
    assign fetch_valid = head_valid;

endmodule

/* hw/fetch_queue.sv */
// circular fifo of fetched pc and predicted next pc
// valid/ready on both sides, flush empties it
`timescale 1ns/100ps
`include "bp_settings.svh"

module fetch_queue (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        push_valid,
    input  logic [31:0] push_pc,
    input  logic [31:0] push_pred,
    input  logic        head_ready,
    output logic        push_ready,
    output logic        head_valid,
    output logic [31:0] head_pc,
    output logic [31:0] head_pred
);

    localparam int PTR_W = $clog2(`BP_QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = `BP_QUEUE_DEPTH;

    // payload storage
    logic [31:0] pc_mem   [`BP_QUEUE_DEPTH];
    logic [31:0] pred_mem [`BP_QUEUE_DEPTH];

    // pointers wrap by overflow, depth is a power of two
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic do_push;
    logic do_pop;

    assign push_ready = (count != FULL_CNT);
    assign head_valid = (count != '0);
    assign do_push    = push_valid && push_ready;
    assign do_pop     = head_valid && head_ready;

    assign head_pc   = pc_mem[rd_ptr];
    assign head_pred = pred_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // flush wins over push and pop
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr]   <= push_pc;
            pred_mem[wr_ptr] <= push_pred;
        end
    end

endmodule

/* hw/pc_gen.sv */
// fetch pc generator
// follows buffer predictions, stalls on back-pressure, takes redirects
`timescale 1ns/100ps
`include "bp_settings.svh"

module pc_gen (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] pred_pc,
    input  logic        push_ready,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    output logic [31:0] lookup_pc,
    output logic        push_valid,
    output logic [31:0] push_pc,
    output logic [31:0] push_pred
);

    // current fetch address
    logic [31:0] pc_q;
    // offer enable, dropped for one cycle after reset or redirect
    logic        valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q    <= `BP_RESET_PC;
            valid_q <= 1'b0;
        end else if (redirect_valid) begin
            // redirect beats any push this cycle
            // queue is flushing so that push is dropped anyway
            pc_q    <= redirect_pc;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
            // advance only on an accepted push
            if (push_valid && push_ready) begin
                pc_q <= pred_pc;
            end
        end
    end

    // buffer lookup runs on the pc being offered
    assign lookup_pc = pc_q;

    // pc and its predicted successor go into the queue together
    assign push_valid = valid_q;
    assign push_pc    = pc_q;
    assign push_pred  = pred_pc;

endmodule

/* hw/two_bit_btb.sv */
// direct-mapped branch target buffer with 2-bit counters
// lookup is combinational, updates are registered then written
`timescale 1ns/100ps
`include "bp_settings.svh"

module two_bit_btb (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] lookup_pc,
    input  logic        upd_valid,
    input  logic [31:0] upd_pc,
    input  logic        upd_is_br,
    input  logic        upd_taken,
    input  logic [31:0] upd_target,
    output logic [31:0] pred_pc
);

    localparam int ENTRIES = 1 << `BP_INDEX_BITS;

    // per-entry state, only the valid bits see reset
    logic [ENTRIES-1:0] valid_q;
    logic [31:0]        tag_mem    [ENTRIES];
    logic [31:0]        target_mem [ENTRIES];
    bp_pkg::ctr_t       ctr_mem    [ENTRIES];

    // update record held one cycle before the table write
    logic        s_valid;
    logic [31:0] s_pc;
    logic        s_is_br;
    logic        s_taken;
    logic [31:0] s_target;

    logic [`BP_INDEX_BITS-1:0] look_idx;
    logic [`BP_INDEX_BITS-1:0] upd_idx;
    logic                      look_hit;
    logic                      upd_hit;
    bp_pkg::ctr_t              ctr_base;

    // one step toward the outcome, pinned at 00 and 11
    function automatic bp_pkg::ctr_t ctr_step(input bp_pkg::ctr_t c, input logic taken);
        bp_pkg::ctr_t n;
        n = c;
        if (taken && c != 2'b11) begin
            n = c + 2'd1;
        end else if (!taken && c != 2'b00) begin
            n = c - 2'd1;
        end
        return n;
    endfunction

    // index skips the two alignment bits
    assign look_idx = lookup_pc[`BP_INDEX_BITS+1:2];
    assign upd_idx  = s_pc[`BP_INDEX_BITS+1:2];

    // tag holds the full pc, so aliases never hit
    assign look_hit = valid_q[look_idx] && (tag_mem[look_idx] == lookup_pc);
    assign upd_hit  = valid_q[upd_idx] && (tag_mem[upd_idx] == s_pc);

    // miss or aliased entry restarts from the allocation value
    assign ctr_base = upd_hit ? ctr_mem[upd_idx] : bp_pkg::CTR_INIT;

    // upper counter bit set means take the stored target
    assign pred_pc = (look_hit && ctr_mem[look_idx][1]) ? target_mem[look_idx]
                                                        : lookup_pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            s_valid <= 1'b0;
            valid_q <= '0;
        end else begin
            s_valid <= upd_valid;
            if (s_valid) begin
                // non-branch drops the entry, branch (re)claims it
                valid_q[upd_idx] <= s_is_br;
            end
        end
    end

    always_ff @(posedge clk) begin
        s_pc     <= upd_pc;
        s_is_br  <= upd_is_br;
        s_taken  <= upd_taken;
        s_target <= upd_target;
        if (s_valid && s_is_br) begin
            tag_mem[upd_idx] <= s_pc;
            ctr_mem[upd_idx] <= ctr_step(ctr_base, s_taken);
            if (s_taken) begin
                target_mem[upd_idx] <= s_target;
            end
        end
    end

endmodule

/* include/bp_settings.svh */
// sizing and reset address of the fetch predictor
// shared by the buffer, queue, generator and testbench
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// buffer index bits, taken from pc[BP_INDEX_BITS+1:2]
// 10 bits gives 1024 entries
`define BP_INDEX_BITS 10

// fetch queue entries
// must stay a power of two, pointers wrap by overflow
`define BP_QUEUE_DEPTH 4

// first fetch address out of reset
// word aligned, no compressed instructions
`define BP_RESET_PC 32'h0000_1000

`endif

/* verification/fetch_predict_properties.sv */
// concurrent checks on queue handshakes and redirect pulses
`timescale 1ns/100ps

module fetch_predict_properties (
    input logic        clk,
    input logic        rst,
    input logic        push_valid,
    input logic        push_ready,
    input logic [31:0] push_pc,
    input logic        head_valid,
    input logic        head_ready,
    input logic        redirect_valid,
    input logic        retire_valid
);

    // a retire needs a valid head taken the cycle before
    a_pop_valid: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> $past(head_valid && head_ready))
        else $error("retire without a valid popped head");

    // redirect is a single-cycle pulse
    a_redirect_pulse: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |=> !redirect_valid)
        else $error("redirect_valid held longer than one cycle");

    // generator idles one cycle after a redirect
    a_idle_after_redirect: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |=> !push_valid)
        else $error("push offered right after a redirect");

    // full queue, offered pc must not move
    a_hold_when_full: assert property (@(posedge clk) disable iff (rst)
        (push_valid && !push_ready && !redirect_valid) |=> $stable(push_pc))
        else $error("push pc changed while the queue was full");

endmodule

/* verification/tb_fetch_predict.sv */
// testbench for the fetch predictor
// memory model, directed tests, compare tasks and summary
`timescale 1ns/100ps
`include "bp_settings.svh"

module tb_fetch_predict;

    localparam int WAIT_LIMIT = 200;
    localparam int PASS_LIMIT = 60;
    localparam logic [31:0] BASE = `BP_RESET_PC;

    logic              clk;
    logic              rst;
    logic              instr_valid;
    bp_pkg::rv_instr_u instr;
    logic              cond_taken;
    logic [31:0]       fetch_pc;
    logic              fetch_valid;
    logic              redirect_valid;
    logic [31:0]       redirect_pc;
    logic              retire_valid;

    // per-test program words and branch conditions
    bp_pkg::rv_instr_u prog_word [logic [31:0]];
    logic              prog_cond [logic [31:0]];

    logic [31:0] rng_state;
    int          errors;
    int          tests_run;
    int          tests_ok;

    fetch_predict_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .cond_taken     (cond_taken),
        .fetch_pc       (fetch_pc),
        .fetch_valid    (fetch_valid),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .retire_valid   (retire_valid)
    );

    // handshake and redirect checks on the internal wires
    bind fetch_predict_top fetch_predict_properties props0 (
        .clk            (clk),
        .rst            (rst),
        .push_valid     (push_valid),
        .push_ready     (push_ready),
        .push_pc        (push_pc),
        .head_valid     (head_valid),
        .head_ready     (head_ready),
        .redirect_valid (redirect_valid),
        .retire_valid   (retire_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // B format word from a byte offset
    function automatic bp_pkg::rv_instr_u make_branch(input int imm);
        bp_pkg::rv_instr_u u;
        logic [31:0]       v;
        v = imm;
        u = '0;
        u.b.imm12   = v[12];
        u.b.imm11   = v[11];
        u.b.imm10_5 = v[10:5];
        u.b.imm4_1  = v[4:1];
        u.b.rs1     = 5'd1;
        u.b.rs2     = 5'd2;
        u.b.opcode  = bp_pkg::OPC_BRANCH;
        return u;
    endfunction

    function automatic bp_pkg::rv_instr_u make_jal(input int imm);
        bp_pkg::rv_instr_u u;
        logic [31:0]       v;
        v = imm;
        u = '0;
        u.j.imm20    = v[20];
        u.j.imm19_12 = v[19:12];
        u.j.imm11    = v[11];
        u.j.imm10_1  = v[10:1];
        u.j.rd       = 5'd1;
        u.j.opcode   = bp_pkg::OPC_JAL;
        return u;
    endfunction

    // memory model with random op-imm filler
    function automatic bp_pkg::rv_instr_u fetch_word(input logic [31:0] pc);
        bp_pkg::rv_instr_u u;
        if (prog_word.exists(pc)) begin
            u = prog_word[pc];
        end else begin
            rng_state  = xorshift(rng_state);
            u          = rng_state;
            u.b.opcode = 7'b001_0011;
        end
        return u;
    endfunction

    task automatic compare_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %08h expected %08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_instr(input string name, input bp_pkg::rv_instr_u got,
                                 input bp_pkg::rv_instr_u exp);
        if (got !== exp) begin
            $display("ERR %s got %08h expected %08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic apply_reset();
        prog_word.delete();
        prog_cond.delete();
        @(posedge clk);
        rst         <= 1'b1;
        instr_valid <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    // play memory for one head entry and report the pop
    task automatic resolve_one(output logic [31:0] pc, output logic redir,
                               output logic [31:0] rpc);
        bp_pkg::rv_instr_u w;
        int                waited;
        waited = 0;
        pc     = 'x;
        redir  = 1'b0;
        rpc    = 'x;
        @(negedge clk);
        // a head seen during a redirect is about to be flushed
        while (!(fetch_valid && !redirect_valid)) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("no valid queue head appeared within %0d cycles", WAIT_LIMIT);
                errors++;
                return;
            end
            @(negedge clk);
        end
        pc = fetch_pc;
        w  = fetch_word(pc);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        cond_taken  <= prog_cond.exists(pc) ? prog_cond[pc] : 1'b0;
        @(negedge clk);
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        if (retire_valid !== 1'b1) begin
            $display("ERR retire_valid got %0h expected 1 for pc %08h", retire_valid, pc);
            errors++;
        end
        redir = redirect_valid;
        rpc   = redirect_pc;
    endtask

    // run until the given pc pops
    task automatic pass_to(input logic [31:0] target, output logic redir,
                           output logic [31:0] rpc);
        logic [31:0] pc;
        int          steps;
        steps = 0;
        redir = 1'b0;
        rpc   = 'x;
        do begin
            resolve_one(pc, redir, rpc);
            steps++;
        end while (pc !== target && steps < PASS_LIMIT);
        if (pc !== target) begin
            $display("pc %08h never reached within %0d pops", target, PASS_LIMIT);
            errors++;
        end
    endtask

    task automatic expect_redirect(input string name, input logic got, input logic exp,
                                   input logic [31:0] got_pc, input logic [31:0] exp_pc);
        if (got !== exp) begin
            $display("ERR %s redirect_valid got %0h expected %0h", name, got, exp);
            errors++;
        end else if (exp) begin
            compare_pc({name, " redirect_pc"}, got_pc, exp_pc);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    // straight-line code steps by 4 from reset
    task automatic sequential_fetch();
        logic [31:0] pc;
        logic [31:0] rpc;
        logic        redir;
        int          e0;
        e0 = errors;
        apply_reset();
        // queue still empty in the first cycle out of reset
        @(negedge clk);
        if (fetch_valid !== 1'b0) begin
            $display("ERR fetch_valid got %0h expected 0 right after reset", fetch_valid);
            errors++;
        end
        for (int i = 0; i < 8; i++) begin
            resolve_one(pc, redir, rpc);
            compare_pc("fetch_pc", pc, BASE + 4 * i);
            expect_redirect("sequential", redir, 1'b0, rpc, '0);
        end
        end_test("sequential", e0);
    endtask

    // cold taken branch redirects to its target
    task automatic cold_branch();
        logic [31:0] pc;
        logic [31:0] rpc;
        logic        redir;
        int          e0;
        e0 = errors;
        apply_reset();
        prog_word[BASE + 4] = make_branch(32'h40);
        prog_cond[BASE + 4] = 1'b1;
        // beq x1 x2 +64 as the ISA encodes it
        compare_instr("branch word", prog_word[BASE + 4], 32'h0420_8063);
        pass_to(BASE + 4, redir, rpc);
        expect_redirect("first branch", redir, 1'b1, rpc, BASE + 32'h44);
        resolve_one(pc, redir, rpc);
        compare_pc("fetch_pc", pc, BASE + 32'h44);
        end_test("first_branch", e0);
    endtask

    // loop branch at base+8 back to base
    // jal at base+16 closes the fall-through
    task automatic counter_training();
        logic [31:0] rpc;
        logic        redir;
        logic        outcome [6];
        logic        exp_redir [6];
        int          e0;
        e0 = errors;
        // 00->01, 01->10, 10->11, 11->10, 10->01, 01->10
        outcome   = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
        exp_redir = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1};
        apply_reset();
        prog_word[BASE + 8]  = make_branch(-8);
        prog_word[BASE + 16] = make_jal(-16);
        for (int i = 0; i < 6; i++) begin
            prog_cond[BASE + 8] = outcome[i];
            pass_to(BASE + 8, redir, rpc);
            expect_redirect($sformatf("counter pass %0d", i), redir, exp_redir[i], rpc,
                            outcome[i] ? BASE : BASE + 12);
        end
        end_test("counter", e0);
    endtask

    // jal pair bouncing between base+4 and base+0x104
    task automatic jal_training();
        logic [31:0] rpc;
        logic        redir;
        int          e0;
        e0 = errors;
        apply_reset();
        prog_word[BASE + 4]      = make_jal(32'h100);
        prog_word[BASE + 32'h104] = make_jal(-32'h104);
        // jal x1 +256 as the ISA encodes it
        compare_instr("jal word", prog_word[BASE + 4], 32'h1000_00ef);
        pass_to(BASE + 4, redir, rpc);
        expect_redirect("jal first", redir, 1'b1, rpc, BASE + 32'h104);
        pass_to(BASE + 32'h104, redir, rpc);
        expect_redirect("jal back", redir, 1'b1, rpc, BASE);
        // counter at 01 still predicts fall-through
        pass_to(BASE + 4, redir, rpc);
        expect_redirect("jal second", redir, 1'b1, rpc, BASE + 32'h104);
        pass_to(BASE + 4, redir, rpc);
        expect_redirect("jal trained", redir, 1'b0, rpc, '0);
        end_test("jal", e0);
    endtask

    // non-branch at a trained pc drops the entry
    task automatic entry_invalidate();
        logic [31:0] rpc;
        logic        redir;
        int          e0;
        e0 = errors;
        apply_reset();
        prog_word[BASE + 8]  = make_branch(-8);
        prog_cond[BASE + 8]  = 1'b1;
        prog_word[BASE + 16] = make_jal(-16);
        for (int i = 0; i < 3; i++) begin
            pass_to(BASE + 8, redir, rpc);
            expect_redirect($sformatf("train pass %0d", i), redir, i < 2, rpc, BASE);
        end
        prog_word[BASE + 8] = 32'h0000_0013;
        pass_to(BASE + 8, redir, rpc);
        expect_redirect("now non-branch", redir, 1'b1, rpc, BASE + 12);
        pass_to(BASE + 8, redir, rpc);
        expect_redirect("after invalidate", redir, 1'b0, rpc, '0);
        end_test("invalidate", e0);
    endtask

    // memory stalls long enough to fill the queue
    task automatic stall_release();
        logic [31:0] pc;
        logic [31:0] rpc;
        logic        redir;
        int          e0;
        e0 = errors;
        apply_reset();
        repeat (30) @(posedge clk);
        @(negedge clk);
        if (dut0.push_ready !== 1'b0) begin
            $display("ERR push_ready got %0h expected 0 after a long stall", dut0.push_ready);
            errors++;
        end
        for (int i = 0; i < 12; i++) begin
            resolve_one(pc, redir, rpc);
            compare_pc("fetch_pc", pc, BASE + 4 * i);
            expect_redirect("backpressure", redir, 1'b0, rpc, '0);
        end
        end_test("backpressure", e0);
    endtask

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        cond_taken  = 1'b0;
        rng_state   = 32'h4d7c_fa42;
        errors      = 0;
        tests_run   = 0;
        tests_ok    = 0;
        sequential_fetch();
        cold_branch();
        counter_training();
        jal_training();
        entry_invalidate();
        stall_release();
        $display("summary: %0d run, %0d ok, %0d errors", tests_run, tests_ok, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // hard stop well beyond the longest test
    initial begin
        #2ms;
        $display("simulation time limit reached");
        $display("tests failed");
        $finish;
    end

endmodule
